// File: source/ingress_pkg.sv
// Shared widths and types of the ingress merger
// Imported by the RTL modules of the merger and by the testbench

package ingress_pkg;

    //////////////////////////////////////////////////
    // Bus geometry

    // Bytes per bus word
    localparam int DATA_BYTES = 8;

    // Longest packet in words for an MTU of 128 bytes
    localparam int MAX_PKT_WORDS = 16;

    // Width of every statistics counter
    localparam int CNT_WIDTH = 32;

    //////////////////////////////////////////////////
    // Vector types

    // One bus word
    typedef logic [DATA_BYTES*8-1:0] data_t;

    // Byte-valid mask with valid bytes packed from bit 0 upward
    typedef logic [DATA_BYTES-1:0] keep_t;

    // One statistics counter
    typedef logic [CNT_WIDTH-1:0] cnt_t;

endpackage

// File: source/port_rx.sv
// Per-port frame admission for the ingress merger
// Gates frames by port enable and buffer room and keeps the port statistics

`timescale 1ns/10ps

module port_rx #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic                        core_clk_ifc,
    input  logic                        arst_n,
    input  logic                        in_valid,
    input  ingress_pkg::data_t          in_data,
    input  ingress_pkg::keep_t          in_keep,
    input  logic                        in_last,
    input  logic                        port_enable,
    input  logic                        cnt_clear,
    input  logic [$clog2(FIFO_DEPTH):0] free_words,
    output logic                        wr_en,
    output ingress_pkg::data_t          wr_data,
    output ingress_pkg::keep_t          wr_keep,
    output logic                        wr_last,
    output ingress_pkg::cnt_t           frame_cnt,
    output ingress_pkg::cnt_t           drop_cnt,
    output logic                        buf_overflow
);

    import ingress_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCEPT,
        ST_DISCARD
    } rx_state_t;

    rx_state_t state;
    logic      first_beat;
    logic      has_room;
    logic      admit;
    logic      no_room_q;
    logic      frame_done;
    logic      drop_done;

    //////////////////////////////////////////////////
    // Admission at the first beat

    assign first_beat = in_valid && (state == ST_IDLE);
    assign has_room   = (free_words >= MAX_PKT_WORDS);
    assign admit      = first_beat && port_enable && has_room;

    // Beats go to the buffer in the cycle they arrive
    assign wr_en   = in_valid && (admit || (state == ST_ACCEPT));
    assign wr_data = in_data;
    assign wr_keep = in_keep;
    assign wr_last = in_last;

    // Disabled frames are discarded without being counted
    assign frame_done = wr_en && in_last;
    assign drop_done  = in_valid && in_last &&
                        ((first_beat && port_enable && !has_room) ||
                         ((state == ST_DISCARD) && no_room_q));

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            no_room_q <= 1'b0;
        end else if (in_valid) begin
            case (state)
                ST_IDLE: begin
                    no_room_q <= port_enable && !has_room;
                    // Single-beat frames stay in idle
                    if (!in_last) begin
                        state <= admit ? ST_ACCEPT : ST_DISCARD;
                    end
                end
                default: begin
                    if (in_last) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Statistics

    // Clear wins over an increment in the same cycle
    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            frame_cnt    <= '0;
            drop_cnt     <= '0;
            buf_overflow <= 1'b0;
        end else if (cnt_clear) begin
            frame_cnt    <= '0;
            drop_cnt     <= '0;
            buf_overflow <= 1'b0;
        end else begin
            if (frame_done) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
            if (drop_done) begin
                drop_cnt     <= drop_cnt + 1'b1;
                buf_overflow <= 1'b1;
            end
        end
    end

    // Every beat carries at least one byte
    assert property (@(posedge core_clk_ifc) disable iff (!arst_n)
        in_valid |-> (in_keep != '0))
        else $error("port_rx: valid beat with empty keep");

endmodule

// File: source/packet_fifo.sv
// Per-port packet buffer of the ingress merger
// First-word-fall-through word store that reports free space and stored packets

`timescale 1ns/10ps

module packet_fifo #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic                        core_clk_ifc,
    input  logic                        arst_n,
    input  logic                        wr_en,
    input  ingress_pkg::data_t          wr_data,
    input  ingress_pkg::keep_t          wr_keep,
    input  logic                        wr_last,
    input  logic                        rd_en,
    output logic [$clog2(FIFO_DEPTH):0] free_words,
    output logic [$clog2(FIFO_DEPTH):0] pkt_count,
    output ingress_pkg::data_t          rd_data,
    output ingress_pkg::keep_t          rd_keep,
    output logic                        rd_last
);

    import ingress_pkg::*;

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    data_t             data_mem [0:FIFO_DEPTH-1];
    keep_t             keep_mem [0:FIFO_DEPTH-1];
    logic              last_mem [0:FIFO_DEPTH-1];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W:0]   occupancy;
    logic              pkt_in;
    logic              pkt_out;

    //////////////////////////////////////////////////
    // Word store

    always_ff @(posedge core_clk_ifc) begin
        if (wr_en) begin
            data_mem[wr_ptr] <= wr_data;
            keep_mem[wr_ptr] <= wr_keep;
            last_mem[wr_ptr] <= wr_last;
        end
    end

    // Head word is visible before it is popped
    assign rd_data = data_mem[rd_ptr];
    assign rd_keep = keep_mem[rd_ptr];
    assign rd_last = last_mem[rd_ptr];

    //////////////////////////////////////////////////
    // Pointers and fill level

    assign pkt_in     = wr_en && wr_last;
    assign pkt_out    = rd_en && rd_last;
    assign free_words = (ADDR_W+1)'(FIFO_DEPTH) - occupancy;

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
            pkt_count <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            occupancy <= occupancy + (ADDR_W+1)'(wr_en) - (ADDR_W+1)'(rd_en);
            pkt_count <= pkt_count + (ADDR_W+1)'(pkt_in) - (ADDR_W+1)'(pkt_out);
        end
    end

    // Admission upstream leaves room for a whole frame
    assert property (@(posedge core_clk_ifc) disable iff (!arst_n)
        wr_en |-> (occupancy < FIFO_DEPTH))
        else $error("packet_fifo: write into a full buffer");

    // Pops come only from complete packets, never from an empty buffer
    assert property (@(posedge core_clk_ifc) disable iff (!arst_n)
        rd_en |-> (pkt_count != '0) && (occupancy != '0))
        else $error("packet_fifo: read without a stored packet");

endmodule

// File: source/merge_arbiter.sv
// Round-robin packet scheduler of the ingress merger
// Moves whole stored packets from the port buffers onto the converged output bus

`timescale 1ns/10ps

module merge_arbiter #(
    parameter int NUM_PORTS  = 3,
    parameter int FIFO_DEPTH = 64
) (
    input  logic                                       core_clk_ifc,
    input  logic                                       arst_n,
    input  logic [NUM_PORTS-1:0][$clog2(FIFO_DEPTH):0] pkt_count,
    input  ingress_pkg::data_t [NUM_PORTS-1:0]         rd_data,
    input  ingress_pkg::keep_t [NUM_PORTS-1:0]         rd_keep,
    input  logic [NUM_PORTS-1:0]                       rd_last,
    input  logic                                       out_ready,
    output logic [NUM_PORTS-1:0]                       rd_en,
    output logic                                       out_valid,
    output ingress_pkg::data_t                         out_data,
    output ingress_pkg::keep_t                         out_keep,
    output logic                                       out_last,
    output logic [$clog2(NUM_PORTS)-1:0]               out_port
);

    localparam int PORT_W = $clog2(NUM_PORTS);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PICK,
        ST_SEND
    } arb_state_t;

    arb_state_t           state;
    logic [NUM_PORTS-1:0] pending;
    logic [PORT_W-1:0]    last_port;
    logic [PORT_W-1:0]    grant;
    logic [PORT_W-1:0]    next_port;
    logic                 xfer;

    //////////////////////////////////////////////////
    // Round-robin selection

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            pending[p] = (pkt_count[p] != '0);
        end
    end

    // Search starts at the port after the one served last
    always_comb begin : rr_search
        int   idx;
        logic found;
        next_port = last_port;
        found     = 1'b0;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            idx = (int'(last_port) + i) % NUM_PORTS;
            if (!found && pending[idx]) begin
                next_port = PORT_W'(idx);
                found     = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Grant FSM

    assign xfer = (state == ST_SEND) && out_ready;

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            grant     <= '0;
            last_port <= PORT_W'(NUM_PORTS - 1);
        end else begin
            case (state)
                ST_IDLE: begin
                    if (|pending) begin
                        state <= ST_PICK;
                    end
                end
                ST_PICK: begin
                    grant <= next_port;
                    state <= ST_SEND;
                end
                ST_SEND: begin
                    // Grant is held until the last word leaves
                    if (xfer && rd_last[grant]) begin
                        last_port <= grant;
                        state     <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign out_valid = (state == ST_SEND);
    assign out_data  = rd_data[grant];
    assign out_keep  = rd_keep[grant];
    assign out_last  = rd_last[grant];
    assign out_port  = grant;

    always_comb begin
        rd_en = '0;
        if (xfer) begin
            rd_en[grant] = 1'b1;
        end
    end

    // A stalled word stays put until the sink takes it
    assert property (@(posedge core_clk_ifc) disable iff (!arst_n)
        (out_valid && !out_ready) |=> out_valid && $stable(out_data) && $stable(out_keep)
                                      && $stable(out_last) && $stable(out_port))
        else $error("merge_arbiter: output changed under back-pressure");

    // Granted buffer holds a complete packet for the whole send
    assert property (@(posedge core_clk_ifc) disable iff (!arst_n)
        (state == ST_SEND) |-> pending[grant])
        else $error("merge_arbiter: sending from a port without a packet");

endmodule

// File: source/ingress_merge.sv
// Top level of the ingress merger
// One receiver and one packet buffer per ingress port feed the round-robin arbiter

`timescale 1ns/10ps

module ingress_merge #(
    parameter int NUM_PORTS  = 3,
    parameter int FIFO_DEPTH = 64
) (
    input  logic                              core_clk_ifc,
    input  logic                              arst_n,
    input  logic [NUM_PORTS-1:0]              in_valid,
    input  ingress_pkg::data_t [NUM_PORTS-1:0] in_data,
    input  ingress_pkg::keep_t [NUM_PORTS-1:0] in_keep,
    input  logic [NUM_PORTS-1:0]              in_last,
    input  logic [NUM_PORTS-1:0]              port_enable,
    input  logic [NUM_PORTS-1:0]              cnt_clear,
    input  logic                              out_ready,
    output logic                              out_valid,
    output ingress_pkg::data_t                out_data,
    output ingress_pkg::keep_t                out_keep,
    output logic                              out_last,
    output logic [$clog2(NUM_PORTS)-1:0]      out_port,
    output ingress_pkg::cnt_t [NUM_PORTS-1:0] frame_cnt,
    output ingress_pkg::cnt_t [NUM_PORTS-1:0] drop_cnt,
    output logic [NUM_PORTS-1:0]              buf_overflow
);

    import ingress_pkg::*;

    localparam int FILL_W = $clog2(FIFO_DEPTH) + 1;

    logic [NUM_PORTS-1:0]             wr_en;
    data_t [NUM_PORTS-1:0]            wr_data;
    keep_t [NUM_PORTS-1:0]            wr_keep;
    logic [NUM_PORTS-1:0]             wr_last;
    logic [NUM_PORTS-1:0][FILL_W-1:0] free_words;
    logic [NUM_PORTS-1:0][FILL_W-1:0] pkt_count;
    data_t [NUM_PORTS-1:0]            rd_data;
    keep_t [NUM_PORTS-1:0]            rd_keep;
    logic [NUM_PORTS-1:0]             rd_last;
    logic [NUM_PORTS-1:0]             rd_en;

    //////////////////////////////////////////////////
    // Ingress lanes

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        port_rx #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_port_rx (
            .core_clk_ifc (core_clk_ifc),
            .arst_n       (arst_n),
            .in_valid     (in_valid[i]),
            .in_data      (in_data[i]),
            .in_keep      (in_keep[i]),
            .in_last      (in_last[i]),
            .port_enable  (port_enable[i]),
            .cnt_clear    (cnt_clear[i]),
            .free_words   (free_words[i]),
            .wr_en        (wr_en[i]),
            .wr_data      (wr_data[i]),
            .wr_keep      (wr_keep[i]),
            .wr_last      (wr_last[i]),
            .frame_cnt    (frame_cnt[i]),
            .drop_cnt     (drop_cnt[i]),
            .buf_overflow (buf_overflow[i])
        );

        packet_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_packet_fifo (
            .core_clk_ifc (core_clk_ifc),
            .arst_n       (arst_n),
            .wr_en        (wr_en[i]),
            .wr_data      (wr_data[i]),
            .wr_keep      (wr_keep[i]),
            .wr_last      (wr_last[i]),
            .rd_en        (rd_en[i]),
            .free_words   (free_words[i]),
            .pkt_count    (pkt_count[i]),
            .rd_data      (rd_data[i]),
            .rd_keep      (rd_keep[i]),
            .rd_last      (rd_last[i])
        );
    end

    //////////////////////////////////////////////////
    // Converged output

    merge_arbiter #(
        .NUM_PORTS  (NUM_PORTS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_merge_arbiter (
        .core_clk_ifc (core_clk_ifc),
        .arst_n       (arst_n),
        .pkt_count    (pkt_count),
        .rd_data      (rd_data),
        .rd_keep      (rd_keep),
        .rd_last      (rd_last),
        .out_ready    (out_ready),
        .rd_en        (rd_en),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_keep     (out_keep),
        .out_last     (out_last),
        .out_port     (out_port)
    );

endmodule

// File: tb/ingress_merge_tb.sv
// Testbench of the ingress merger
// Sends frames into the ports and checks the merged stream against per-port queues

`timescale 1ns/10ps

module ingress_merge_tb;

    import ingress_pkg::*;

    localparam int NUM_PORTS  = 3;
    localparam int FIFO_DEPTH = 64;
    localparam int PORT_W     = $clog2(NUM_PORTS);

    // About 60 packets of up to 16 words with gaps and arbitration, plus quiet
    // windows, take roughly 2000 cycles
    localparam int TIMEOUT_CYCLES = 20000;

    logic                  core_clk_ifc;
    logic                  arst_n;
    logic [NUM_PORTS-1:0]  in_valid;
    data_t [NUM_PORTS-1:0] in_data;
    keep_t [NUM_PORTS-1:0] in_keep;
    logic [NUM_PORTS-1:0]  in_last;
    logic [NUM_PORTS-1:0]  port_enable;
    logic [NUM_PORTS-1:0]  cnt_clear;
    logic                  out_ready;
    logic                  out_valid;
    data_t                 out_data;
    keep_t                 out_keep;
    logic                  out_last;
    logic [PORT_W-1:0]     out_port;
    cnt_t [NUM_PORTS-1:0]  frame_cnt;
    cnt_t [NUM_PORTS-1:0]  drop_cnt;
    logic [NUM_PORTS-1:0]  buf_overflow;

    // Expected words per port, in sending order
    data_t exp_data [NUM_PORTS][$];
    keep_t exp_keep [NUM_PORTS][$];
    logic  exp_last [NUM_PORTS][$];

    integer seed;
    int     errors;
    int     rx_packets;
    int     valid_cycles;
    cnt_t   snap_frames [NUM_PORTS];
    cnt_t   snap_drops [NUM_PORTS];

    initial begin
        core_clk_ifc = 1'b0;
        forever #10 core_clk_ifc = ~core_clk_ifc;
    end

    ingress_merge #(
        .NUM_PORTS  (NUM_PORTS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_ingress_merge (
        .core_clk_ifc (core_clk_ifc),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .in_keep      (in_keep),
        .in_last      (in_last),
        .port_enable  (port_enable),
        .cnt_clear    (cnt_clear),
        .out_ready    (out_ready),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_keep     (out_keep),
        .out_last     (out_last),
        .out_port     (out_port),
        .frame_cnt    (frame_cnt),
        .drop_cnt     (drop_cnt),
        .buf_overflow (buf_overflow)
    );

    //////////////////////////////////////////////////
    // Checking helpers

    task automatic check_value(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("Failure: %s", what);
        errors++;
    endtask

    // Valid bytes fill the word from bit 0 upward
    function automatic keep_t tail_keep(input int nbytes);
        keep_t k;
        k = '0;
        for (int b = 0; b < nbytes; b++) begin
            k[b] = 1'b1;
        end
        return k;
    endfunction

    function automatic int random_length();
        return 1 + int'($unsigned($random(seed)) % MAX_PKT_WORDS);
    endfunction

    function automatic bit queues_empty();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (exp_data[p].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic snapshot_counters();
        for (int p = 0; p < NUM_PORTS; p++) begin
            snap_frames[p] = frame_cnt[p];
            snap_drops[p]  = drop_cnt[p];
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus

    // Drives one frame on a port and queues it when the port should admit it
    task automatic send_frame(input int port, input int nwords, input bit admit);
        int    nbytes;
        data_t word;
        keep_t keep;
        nbytes = 1 + int'($unsigned($random(seed)) % DATA_BYTES);
        for (int w = 0; w < nwords; w++) begin
            word = {$random(seed), $random(seed)};
            keep = (w == nwords - 1) ? tail_keep(nbytes) : '1;
            in_valid[port] = 1'b1;
            in_data[port]  = word;
            in_keep[port]  = keep;
            in_last[port]  = (w == nwords - 1);
            if (admit) begin
                exp_data[port].push_back(word);
                exp_keep[port].push_back(keep);
                exp_last[port].push_back(w == nwords - 1);
            end
            @(posedge core_clk_ifc);
            #2;
        end
        in_valid[port] = 1'b0;
        in_last[port]  = 1'b0;
        // One idle cycle between frames
        @(posedge core_clk_ifc);
        #2;
    endtask

    task automatic wait_drain();
        while (!queues_empty()) begin
            @(negedge core_clk_ifc);
        end
        repeat (4) @(posedge core_clk_ifc);
        #2;
    endtask

    //////////////////////////////////////////////////
    // Receive monitor

    always @(negedge core_clk_ifc) begin : rx_monitor
        int p;
        if (arst_n && out_valid) begin
            valid_cycles++;
            if (out_ready) begin
                p = int'(out_port);
                if (p >= NUM_PORTS || exp_data[p].size() == 0) begin
                    report_failure($sformatf("word from port %0d with no packet expected", p));
                end else begin
                    check_value("out_data", out_data, exp_data[p].pop_front());
                    check_value("out_keep", out_keep, exp_keep[p].pop_front());
                    check_value("out_last", out_last, exp_last[p].pop_front());
                    if (out_last) begin
                        rx_packets++;
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Directed tests

    task automatic check_reset_state();
        check_value("out_valid", out_valid, 0);
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_value($sformatf("frame_cnt[%0d]", p), frame_cnt[p], 0);
            check_value($sformatf("drop_cnt[%0d]", p), drop_cnt[p], 0);
            check_value($sformatf("buf_overflow[%0d]", p), buf_overflow[p], 0);
        end
    endtask

    task automatic all_ports_traffic();
        port_enable = '1;
        out_ready   = 1'b1;
        for (int f = 0; f < 10; f++) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                send_frame(p, random_length(), 1'b1);
            end
        end
        wait_drain();
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_value($sformatf("frame_cnt[%0d]", p), frame_cnt[p], 10);
            check_value($sformatf("drop_cnt[%0d]", p), drop_cnt[p], 0);
            check_value($sformatf("buf_overflow[%0d]", p), buf_overflow[p], 0);
        end
    endtask

    task automatic all_ports_disabled();
        int valid_before;
        valid_before = valid_cycles;
        snapshot_counters();
        port_enable = '0;
        for (int f = 0; f < 5; f++) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                send_frame(p, random_length(), 1'b0);
            end
        end
        repeat (200) @(posedge core_clk_ifc);
        #2;
        if (valid_cycles != valid_before) begin
            report_failure("out_valid rose while every port was disabled");
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_value($sformatf("frame_cnt[%0d]", p), frame_cnt[p], snap_frames[p]);
            check_value($sformatf("drop_cnt[%0d]", p), drop_cnt[p], snap_drops[p]);
        end
    endtask

    task automatic one_port_disabled();
        snapshot_counters();
        port_enable    = '1;
        port_enable[0] = 1'b0;
        for (int f = 0; f < 5; f++) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                send_frame(p, random_length(), p != 0);
            end
        end
        wait_drain();
        check_value("frame_cnt[0]", frame_cnt[0], snap_frames[0]);
        for (int p = 1; p < NUM_PORTS; p++) begin
            check_value($sformatf("frame_cnt[%0d]", p), frame_cnt[p], snap_frames[p] + 5);
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_value($sformatf("drop_cnt[%0d]", p), drop_cnt[p], snap_drops[p]);
        end
    endtask

    task automatic counter_clear();
        // Port 1 overflows first so the clear has a drop and a flag to undo
        out_ready = 1'b0;
        for (int f = 0; f < 5; f++) begin
            send_frame(1, MAX_PKT_WORDS, f < FIFO_DEPTH / MAX_PKT_WORDS);
        end
        check_value("buf_overflow[1]", buf_overflow[1], 1);
        snapshot_counters();
        cnt_clear[1] = 1'b1;
        @(posedge core_clk_ifc);
        #2;
        cnt_clear[1] = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_value($sformatf("frame_cnt[%0d]", p), frame_cnt[p],
                        (p == 1) ? '0 : snap_frames[p]);
            check_value($sformatf("drop_cnt[%0d]", p), drop_cnt[p],
                        (p == 1) ? '0 : snap_drops[p]);
        end
        check_value("buf_overflow[1]", buf_overflow[1], 0);
        out_ready = 1'b1;
        wait_drain();
    endtask

    task automatic backpressure_overflow();
        int accepted;
        accepted = FIFO_DEPTH / MAX_PKT_WORDS;
        snapshot_counters();
        port_enable = '1;
        out_ready   = 1'b0;
        // A frame is admitted only while a full-length packet still fits
        for (int f = 0; f < 6; f++) begin
            send_frame(0, MAX_PKT_WORDS, f < accepted);
        end
        repeat (4) @(negedge core_clk_ifc);
        check_value("frame_cnt[0]", frame_cnt[0], snap_frames[0] + accepted);
        check_value("drop_cnt[0]", drop_cnt[0], snap_drops[0] + (6 - accepted));
        check_value("buf_overflow[0]", buf_overflow[0], 1);
        for (int n = 0; n < 2; n++) begin
            check_value("out_valid", out_valid, 1);
            check_value("out_port", out_port, 0);
            check_value("out_data", out_data, exp_data[0][0]);
            check_value("out_keep", out_keep, exp_keep[0][0]);
            repeat (8) @(negedge core_clk_ifc);
        end
        @(posedge core_clk_ifc);
        #2;
        out_ready = 1'b1;
        wait_drain();
        repeat (20) @(posedge core_clk_ifc);
        #2;
        check_value("out_valid", out_valid, 0);
    endtask

    //////////////////////////////////////////////////
    // Sequence and closing report

    initial begin : main
        seed         = 32'h40fc_999e;
        errors       = 0;
        rx_packets   = 0;
        valid_cycles = 0;
        arst_n       = 1'b0;
        in_valid     = '0;
        in_data      = '0;
        in_keep      = '0;
        in_last      = '0;
        port_enable  = '0;
        cnt_clear    = '0;
        out_ready    = 1'b0;
        repeat (4) @(posedge core_clk_ifc);
        #2;
        arst_n = 1'b1;
        check_reset_state();
        @(posedge core_clk_ifc);
        #2;
        all_ports_traffic();
        all_ports_disabled();
        one_port_disabled();
        counter_clear();
        backpressure_overflow();
        $display("Closing report: %0d errors, %0d packets received", errors, rx_packets);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge core_clk_ifc);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Closing report: %0d errors, %0d packets received", errors, rx_packets);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: ingress_merge.f
source/ingress_pkg.sv
source/port_rx.sv
source/packet_fifo.sv
source/merge_arbiter.sv
source/ingress_merge.sv
tb/ingress_merge_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = ingress_merge_tb
FILELIST  = ingress_merge.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
